// File: src/ahb_pkg.sv
package ahb_pkg;

        // ----------------------------------------------------------
        // Bus widths
        // ----------------------------------------------------------

        localparam int addr_w = 32;
        localparam int data_w = 32;

        // Byte lanes per data word
        localparam int byte_lanes = data_w / 8;
        // Address bits below the word index
        localparam int word_lsb = $clog2(byte_lanes);

        // ----------------------------------------------------------
        // Region map
        // ----------------------------------------------------------

        // Slave 0 is code RAM, slave 1 is data RAM
        localparam int num_rams = 2;
        // 16K words per RAM
        localparam int ram_addr_w = 14;

        // Region field is the top nibble of the address
        localparam int region_lsb = 28;
        localparam int region_w = addr_w - region_lsb;

        // Region number per slave, index 0 in the low slot
        localparam logic [num_rams-1:0][region_w-1:0] region_base = {
                region_w'(2),
                region_w'(0)
        };

        // ----------------------------------------------------------
        // Transfer encodings
        // ----------------------------------------------------------

        typedef enum logic [1:0] {
                trans_idle   = 2'b00,
                trans_busy   = 2'b01,
                trans_nonseq = 2'b10,
                trans_seq    = 2'b11
        } htrans_t;

        // Sizes above word are illegal on this bus
        typedef enum logic [2:0] {
                size_byte = 3'b000,
                size_half = 3'b001,
                size_word = 3'b010
        } hsize_t;

        // One-hot slave select
        typedef logic [num_rams-1:0] slave_sel_t;

endpackage

// File: src/ahb_decoder.sv
module ahb_decoder (
        input  logic [ahb_pkg::addr_w-1:0] haddr,
        input  ahb_pkg::htrans_t           htrans,
        output ahb_pkg::slave_sel_t        hsel,
        output logic                       hit
);

        import ahb_pkg::*;

        // ----------------------------------------------------------
        // Address-phase decode
        // ----------------------------------------------------------

        // Only nonseq and seq move data
        logic                active;
        // Upper address nibble
        logic [region_w-1:0] region;
        // Region matches, before transfer gating
        slave_sel_t          match;

        assign active = (htrans == trans_nonseq) || (htrans == trans_seq);
        assign region = haddr[region_lsb +: region_w];

        // Compare against every entry of the region table
        always_comb begin
                match = '0;
                for (int i = 0; i < num_rams; i++) begin
                        if (region == region_base[i]) begin
                                match[i] = 1'b1;
                        end
                end
        end

        // Idle and busy select nothing
        assign hsel = active ? match : '0;

        // Low only for an active transfer that no region claims
        // High for idle/busy, so the default slave stays quiet then
        assign hit = !active || (|match);

        // ----------------------------------------------------------
        // Checks
        // ----------------------------------------------------------

        // Overlapping region table entries would select two slaves
        always_comb begin
                assert ($onehot0(hsel))
                else $error("Decoder selects more than one slave");
        end

endmodule

// File: src/ahb_ram_slave.sv
module ahb_ram_slave (
        input  logic                       clk,
        input  logic                       RSTn,
        input  logic                       hsel,
        input  logic [ahb_pkg::addr_w-1:0] haddr,
        input  ahb_pkg::htrans_t           htrans,
        input  ahb_pkg::hsize_t            hsize,
        input  logic                       hwrite,
        input  logic [ahb_pkg::data_w-1:0] hwdata,
        input  logic                       hready,
        output logic [ahb_pkg::data_w-1:0] hrdata,
        output logic                       hreadyout,
        output logic                       hresp
);

        import ahb_pkg::*;

        // ----------------------------------------------------------
        // Address phase
        // ----------------------------------------------------------

        logic                  accept;
        logic [ram_addr_w-1:0] word_addr;
        logic [byte_lanes-1:0] lane_mask;
        logic                  misaligned;

        // Active transfer to this slave, taken while the bus is ready
        assign accept = hsel && hready && htrans[1];
        assign word_addr = haddr[word_lsb +: ram_addr_w];

        // Lanes touched by this size and offset
        always_comb begin
                case (hsize)
                        size_byte: lane_mask = byte_lanes'(1) << haddr[word_lsb-1:0];
                        size_half: lane_mask = byte_lanes'(3) << {haddr[word_lsb-1:1], 1'b0};
                        default:   lane_mask = '1;
                endcase
        end

        assign misaligned = ((hsize == size_half) && haddr[0]) ||
                            ((hsize == size_word) && (haddr[word_lsb-1:0] != '0));

        // ----------------------------------------------------------
        // Data-phase state
        // ----------------------------------------------------------

        // Write data phase in progress for this slave
        logic                  write_q;
        logic                  stall_q;
        logic [ram_addr_w-1:0] addr_q;
        logic [byte_lanes-1:0] mask_q;

        // Control advances only when the bus moves
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        write_q <= 1'b0;
                        stall_q <= 1'b0;
                end else begin
                        if (hready) begin
                                write_q <= accept && hwrite;
                        end
                        // Read right behind our own write sees stale data
                        stall_q <= accept && !hwrite && write_q;
                end
        end

        // Captured address and lanes, held through a stall
        always_ff @(posedge clk) begin
                if (accept) begin
                        addr_q <= word_addr;
                        mask_q <= lane_mask;
                end
        end

        // ----------------------------------------------------------
        // Storage array
        // ----------------------------------------------------------

        logic [data_w-1:0]     mem [2**ram_addr_w];
        logic [data_w-1:0]     rdata_q;
        logic                  wr_en;
        logic                  rd_en;
        logic [ram_addr_w-1:0] rd_index;

        assign wr_en = write_q && hready;
        // Normal read in address phase, re-read from addr_q while stalled
        assign rd_en = (accept && !hwrite) || stall_q;
        assign rd_index = stall_q ? addr_q : word_addr;

        always_ff @(posedge clk) begin
                if (wr_en) begin
                        for (int i = 0; i < byte_lanes; i++) begin
                                if (mask_q[i]) begin
                                        mem[addr_q][i*8 +: 8] <= hwdata[i*8 +: 8];
                                end
                        end
                end
                if (rd_en) begin
                        rdata_q <= mem[rd_index];
                end
        end

        assign hrdata = rdata_q;
        assign hreadyout = !stall_q;
        // RAM never errors
        assign hresp = 1'b0;

        // ----------------------------------------------------------
        // Checks
        // ----------------------------------------------------------

        a_size_legal: assert property (@(posedge clk) disable iff (!RSTn)
                accept |-> (hsize <= size_word))
        else $error("Transfer size above word");

        a_aligned: assert property (@(posedge clk) disable iff (!RSTn)
                accept |-> !misaligned)
        else $error("Transfer not aligned to its size");

endmodule

// File: src/ahb_resp_mux.sv
module ahb_resp_mux (
        input  logic                                      clk,
        input  logic                                      RSTn,
        input  logic                                      hready,
        input  ahb_pkg::slave_sel_t                       hsel,
        input  logic                                      hit,
        input  logic [ahb_pkg::num_rams*ahb_pkg::data_w-1:0] slave_hrdata,
        input  logic [ahb_pkg::num_rams-1:0]              slave_hreadyout,
        input  logic [ahb_pkg::num_rams-1:0]              slave_hresp,
        output logic [ahb_pkg::data_w-1:0]                hrdata,
        output logic                                      hready_out,
        output logic                                      hresp
);

        import ahb_pkg::*;

        // ----------------------------------------------------------
        // Data-phase select
        // ----------------------------------------------------------

        slave_sel_t sel_q;
        // Active transfer missed every region
        logic       miss_q;
        // Second cycle of the error response
        logic       err2_q;

        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        sel_q  <= '0;
                        miss_q <= 1'b0;
                        err2_q <= 1'b0;
                end else begin
                        if (hready) begin
                                sel_q  <= hsel;
                                miss_q <= !hit;
                        end
                        // Error takes one stalled cycle, then completes
                        err2_q <= miss_q && !err2_q;
                end
        end

        // ----------------------------------------------------------
        // Return path
        // ----------------------------------------------------------

        // No selection means idle data phase, zero wait states
        always_comb begin
                hrdata     = '0;
                hready_out = 1'b1;
                hresp      = 1'b0;
                if (miss_q) begin
                        hready_out = err2_q;
                        hresp      = 1'b1;
                end else begin
                        for (int i = 0; i < num_rams; i++) begin
                                if (sel_q[i]) begin
                                        hrdata     = slave_hrdata[i*data_w +: data_w];
                                        hready_out = slave_hreadyout[i];
                                        hresp      = slave_hresp[i];
                                end
                        end
                end
        end

        // Two-cycle error response as AHB-Lite requires
        a_err_two_cycle: assert property (@(posedge clk) disable iff (!RSTn)
                (hresp && hready_out) |-> $past(hresp && !hready_out))
        else $error("Error response without its stalled first cycle");

endmodule

// File: src/ahb_mem_subsystem.sv
module ahb_mem_subsystem (
        input  logic                       clk,
        input  logic                       RSTn,
        input  logic [ahb_pkg::addr_w-1:0] haddr,
        input  ahb_pkg::htrans_t           htrans,
        input  ahb_pkg::hsize_t            hsize,
        input  logic                       hwrite,
        input  logic [ahb_pkg::data_w-1:0] hwdata,
        output logic [ahb_pkg::data_w-1:0] hrdata,
        output logic                       hready,
        output logic                       hresp
);

        import ahb_pkg::*;

        // ----------------------------------------------------------
        // Address decode
        // ----------------------------------------------------------

        slave_sel_t                  hsel;
        logic                        hit;
        // Flattened slave responses, slave i in slot i
        logic [num_rams*data_w-1:0]  slave_hrdata;
        logic [num_rams-1:0]         slave_hreadyout;
        logic [num_rams-1:0]         slave_hresp;

        ahb_decoder u_decoder (
                .haddr  (haddr),
                .htrans (htrans),
                .hsel   (hsel),
                .hit    (hit)
        );

        // ----------------------------------------------------------
        // RAM slaves, code then data
        // ----------------------------------------------------------

        for (genvar i = 0; i < num_rams; i++) begin : g_ram
                ahb_ram_slave u_ram (
                        .clk       (clk),
                        .RSTn      (RSTn),
                        .hsel      (hsel[i]),
                        .haddr     (haddr),
                        .htrans    (htrans),
                        .hsize     (hsize),
                        .hwrite    (hwrite),
                        .hwdata    (hwdata),
                        .hready    (hready),
                        .hrdata    (slave_hrdata[i*data_w +: data_w]),
                        .hreadyout (slave_hreadyout[i]),
                        .hresp     (slave_hresp[i])
                );
        end

        // Response mux drives hready back to every slave
        ahb_resp_mux u_resp_mux (
                .clk             (clk),
                .RSTn            (RSTn),
                .hready          (hready),
                .hsel            (hsel),
                .hit             (hit),
                .slave_hrdata    (slave_hrdata),
                .slave_hreadyout (slave_hreadyout),
                .slave_hresp     (slave_hresp),
                .hrdata          (hrdata),
                .hready_out      (hready),
                .hresp           (hresp)
        );

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen #(
        parameter int period       = 40,
        parameter int reset_cycles = 8
) (
        output logic clk,
        output logic RSTn
);

        timeunit 1ns;
        timeprecision 1ps;

        // Free-running clock
        initial begin
                clk = 1'b0;
                forever #(period / 2) clk = ~clk;
        end

        // Reset low for reset_cycles, released on a falling edge
        initial begin
                RSTn = 1'b0;
                repeat (reset_cycles) @(posedge clk);
                @(negedge clk);
                RSTn = 1'b1;
        end

endmodule

// File: testbench/tb_ahb_mem.sv
module tb_ahb_mem;

        timeunit 1ns;
        timeprecision 1ps;

        import ahb_pkg::*;

        localparam int clk_period = 40;
        localparam int rst_cycles = 8;
        // Loop counts per test
        localparam int n_words = 16;
        localparam int n_sub   = 12;
        localparam int n_alias = 4;
        localparam int n_raw   = 4;
        localparam int n_err   = 3;
        localparam int num_xfers = 2 * n_words + 3 * n_sub + 4 * n_alias + 3 * n_raw + 2 * n_err;
        localparam longint watchdog_ns = longint'(num_xfers * 6 + rst_cycles) * clk_period;
        // Region nibbles of code RAM and data RAM
        localparam logic [3:0] code_region = 4'h0;
        localparam logic [3:0] data_region = 4'h2;

        logic              clk;
        logic              RSTn;
        logic [addr_w-1:0] haddr;
        htrans_t           htrans;
        hsize_t            hsize;
        logic              hwrite;
        logic [data_w-1:0] hwdata;
        logic [data_w-1:0] hrdata;
        logic              hready;
        logic              hresp;

        // Data-phase markers, driven with the stimulus
        bit                no_xfer_yet = 1'b1;
        bit                rd_phase;
        bit                raw_phase;
        bit                err_phase;
        bit                idle_phase;
        logic [data_w-1:0] rd_exp;
        int                data_errs;
        int                proto_errs;
        logic [31:0]       rng_state = 32'd96548;
        // Byte-lane reference, key is {region, word}
        logic [data_w-1:0] ref_mem [int];

        tb_clock_gen #(.period(clk_period), .reset_cycles(rst_cycles)) u_clk (
                .clk  (clk),
                .RSTn (RSTn)
        );

        ahb_mem_subsystem dut0 (
                .clk    (clk),
                .RSTn   (RSTn),
                .haddr  (haddr),
                .htrans (htrans),
                .hsize  (hsize),
                .hwrite (hwrite),
                .hwdata (hwdata),
                .hrdata (hrdata),
                .hready (hready),
                .hresp  (hresp)
        );

        // ----------------------------------------------------------
        // Helpers
        // ----------------------------------------------------------

        function automatic logic [31:0] next_rand();
                rng_state ^= rng_state << 13;
                rng_state ^= rng_state >> 17;
                rng_state ^= rng_state << 5;
                return rng_state;
        endfunction

        function automatic logic [31:0] make_addr(logic [3:0] region, logic [13:0] word,
                                                  logic [1:0] offset);
                return {region, 12'h000, word, offset};
        endfunction

        // Merge the lanes a write of this size and offset touches
        function automatic void ref_write(logic [3:0] region, logic [13:0] word,
                                          logic [1:0] offset, hsize_t size, logic [31:0] data);
                logic [3:0]  mask;
                logic [31:0] cur;
                int          key;
                key = int'({region, word});
                cur = ref_mem.exists(key) ? ref_mem[key] : '0;
                case (size)
                        size_byte: mask = 4'b0001 << offset;
                        size_half: mask = 4'b0011 << offset;
                        default:   mask = 4'b1111;
                endcase
                for (int i = 0; i < 4; i++) begin
                        if (mask[i]) begin
                                cur[i*8 +: 8] = data[i*8 +: 8];
                        end
                end
                ref_mem[key] = cur;
        endfunction

        task automatic log_fail(input bit is_data, input string msg);
                if (is_data) begin
                        data_errs++;
                end else begin
                        proto_errs++;
                end
                $display("Fail %0t: %s", $time, msg);
        endtask

        // Returns on the falling edge after a rising edge with hready high
        task automatic wait_accept();
                while (!hready) begin
                        @(negedge clk);
                end
                @(negedge clk);
        endtask

        // One transfer, then an idle address phase during its data phase
        task automatic xfer(input logic [31:0] addr, input htrans_t trans, input hsize_t size,
                            input logic write, input logic [31:0] wdata, input logic [31:0] exp);
                logic active;
                logic mapped;
                active = (trans == trans_nonseq) || (trans == trans_seq);
                mapped = (addr[31:28] == code_region) || (addr[31:28] == data_region);
                haddr = addr;
                htrans = trans;
                hsize = size;
                hwrite = write;
                no_xfer_yet = 1'b0;
                wait_accept();
                htrans = trans_idle;
                hwdata = wdata;
                rd_exp = exp;
                rd_phase = active && mapped && !write;
                err_phase = active && !mapped;
                idle_phase = !active;
                wait_accept();
                rd_phase = 1'b0;
                err_phase = 1'b0;
                idle_phase = 1'b0;
        endtask

        task automatic write_ram(input logic [3:0] region, input logic [13:0] word,
                                 input logic [1:0] offset, input hsize_t size,
                                 input logic [31:0] data);
                ref_write(region, word, offset, size, data);
                xfer(make_addr(region, word, offset), trans_nonseq, size, 1'b1, data, '0);
        endtask

        task automatic read_ram(input logic [3:0] region, input logic [13:0] word);
                xfer(make_addr(region, word, 2'b00), trans_nonseq, size_word, 1'b0, '0,
                     ref_mem[int'({region, word})]);
        endtask

        // Read address phase overlaps the write data phase
        task automatic write_then_read(input logic [3:0] region, input logic [13:0] word,
                                       input logic [31:0] data);
                ref_write(region, word, 2'b00, size_word, data);
                haddr = make_addr(region, word, 2'b00);
                htrans = trans_nonseq;
                hsize = size_word;
                hwrite = 1'b1;
                wait_accept();
                hwdata = data;
                hwrite = 1'b0;
                wait_accept();
                htrans = trans_idle;
                rd_exp = ref_mem[int'({region, word})];
                rd_phase = 1'b1;
                raw_phase = 1'b1;
                wait_accept();
                rd_phase = 1'b0;
                raw_phase = 1'b0;
        endtask

        // ----------------------------------------------------------
        // Checkers
        // ----------------------------------------------------------

        a_reset_idle: assert property (@(posedge clk) (RSTn && no_xfer_yet) |-> (hready && !hresp))
        else log_fail(1'b0, "bus not idle after reset");

        a_rd_data: assert property (@(posedge clk) disable iff (!RSTn)
                (rd_phase && hready) |-> (hrdata == rd_exp))
        else log_fail(1'b1, $sformatf("read %h, expected %h", $sampled(hrdata), $sampled(rd_exp)));

        // Read behind a write to the same RAM stalls exactly once
        a_raw_stall: assert property (@(posedge clk) disable iff (!RSTn) $rose(raw_phase) |-> !hready)
        else log_fail(1'b0, "no wait state on read after write");

        a_raw_done: assert property (@(posedge clk) disable iff (!RSTn)
                (raw_phase && $past(raw_phase)) |-> hready)
        else log_fail(1'b0, "read after write stalled more than one cycle");

        // Unmapped access, two-cycle error
        a_err_first: assert property (@(posedge clk) disable iff (!RSTn)
                $rose(err_phase) |-> (!hready && hresp))
        else log_fail(1'b0, "first error cycle wrong");

        a_err_second: assert property (@(posedge clk) disable iff (!RSTn)
                (err_phase && $past(err_phase)) |-> (hready && hresp))
        else log_fail(1'b0, "second error cycle wrong");

        a_idle_quiet: assert property (@(posedge clk) disable iff (!RSTn)
                idle_phase |-> (hready && !hresp))
        else log_fail(1'b0, "idle transfer got a wait state or error");

        // ----------------------------------------------------------
        // Stimulus
        // ----------------------------------------------------------

        initial begin : stimulus
                logic [31:0] rnd;
                logic [3:0]  region;
                logic [13:0] word;
                hsize_t      sz;
                logic [3:0]  t_region [n_words];
                logic [13:0] t_word [n_words];
                haddr = '0;
                htrans = trans_idle;
                hsize = size_word;
                hwrite = 1'b0;
                hwdata = '0;
                @(posedge RSTn);
                repeat (3) @(negedge clk);
                // Word writes, read back after all writes
                for (int i = 0; i < n_words; i++) begin
                        rnd = next_rand();
                        t_region[i] = rnd[31] ? data_region : code_region;
                        t_word[i] = rnd[13:0];
                        write_ram(t_region[i], t_word[i], 2'b00, size_word, next_rand());
                end
                for (int i = 0; i < n_words; i++) begin
                        read_ram(t_region[i], t_word[i]);
                end
                // Byte and halfword lanes over a full word
                for (int i = 0; i < n_sub; i++) begin
                        rnd = next_rand();
                        region = rnd[31] ? data_region : code_region;
                        sz = rnd[30] ? size_half : size_byte;
                        write_ram(region, rnd[13:0], 2'b00, size_word, next_rand());
                        write_ram(region, rnd[13:0], (sz == size_half) ? {rnd[15], 1'b0} : rnd[15:14],
                                  sz, next_rand());
                        read_ram(region, rnd[13:0]);
                end
                // Same offset in both regions
                for (int i = 0; i < n_alias; i++) begin
                        rnd = next_rand();
                        word = rnd[13:0];
                        write_ram(code_region, word, 2'b00, size_word, next_rand());
                        write_ram(data_region, word, 2'b00, size_word, next_rand());
                        read_ram(code_region, word);
                        read_ram(data_region, word);
                end
                // Back-to-back write and read, old value first
                for (int i = 0; i < n_raw; i++) begin
                        rnd = next_rand();
                        region = rnd[31] ? data_region : code_region;
                        write_ram(region, rnd[13:0], 2'b00, size_word, next_rand());
                        write_then_read(region, rnd[13:0], next_rand());
                end
                // Unmapped region, active then idle
                for (int i = 0; i < n_err; i++) begin
                        rnd = next_rand();
                        region = rnd[3:0];
                        if ((region == code_region) || (region == data_region)) begin
                                region = region + 4'd1;
                        end
                        xfer(make_addr(region, rnd[17:4], 2'b00), trans_nonseq, size_word,
                             rnd[31], next_rand(), '0);
                        xfer(make_addr(region, rnd[17:4], 2'b00), trans_idle, size_word,
                             1'b0, '0, '0);
                end
                repeat (2) @(negedge clk);
                $display("Errors: %0d data, %0d protocol", data_errs, proto_errs);
                if ((data_errs + proto_errs) == 0) begin
                        $display("All checks passed");
                end else begin
                        $display("Checks failed");
                end
                $finish;
        end

        // Run limit from the transfer count
        initial begin : watchdog
                #(watchdog_ns);
                $display("Watchdog expired, a transfer never completed");
                $display("Errors: %0d data, %0d protocol", data_errs, proto_errs);
                $display("Checks failed");
                $finish;
        end

endmodule

// File: flist.f
src/ahb_pkg.sv
src/ahb_decoder.sv
src/ahb_ram_slave.sv
src/ahb_resp_mux.sv
src/ahb_mem_subsystem.sv
testbench/tb_clock_gen.sv
testbench/tb_ahb_mem.sv

// File: Makefile
# Verilator build and run of the AHB-Lite memory subsystem testbench

TOP             ?= tb_ahb_mem
FLIST           ?= flist.f
OBJ_DIR         ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG        := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables (override on the command line):"
	@echo "  TOP=$(TOP) FLIST=$(FLIST) OBJ_DIR=$(OBJ_DIR)"
	@echo "  VERILATOR=$(VERILATOR)"
	@echo "  VERILATOR_FLAGS=$(VERILATOR_FLAGS)"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
